/* list.f */
lane_config_pkg.sv
lane_packet_pkg.sv
lane_sync_fifo.sv
lane_request_arbiter.sv
lane_response_router.sv
lane_memory_port.sv
lane_memory_port_tb.sv

/* run.sh */
#!/bin/sh
# Build the lane memory port testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --timescale 1ns/100ps -f list.f --top-module lane_memory_port_tb \
    -o lane_memory_port_tb > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/lane_memory_port_tb > sim.log 2>&1 || echo "ERRORS FOUND" >> sim.log
cat sim.log
grep -q "ERRORS FOUND" sim.log && exit 1 || exit 0

/* lane_memory_port_tb.sv */
// Self-checking testbench that plays the engines and the memory side around the lane memory port
`timescale 1ns/100ps
`default_nettype none

module lane_memory_port_tb;

    import lane_config_pkg::*;
    import lane_packet_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 5;
    localparam int REQ_RR       = 10;
    localparam int REQ_BP       = 15;
    localparam int NUM_RESP     = 60;
    localparam int RESP_LIMIT   = 12;
    localparam int TRANSFERS    = NUM_ENGINES * (REQ_RR + REQ_BP) + NUM_RESP;
    localparam int WATCHDOG_NS  = CLK_PERIOD * TRANSFERS * 8;

    logic                   ap_clk;
    logic                   areset_lane_template;
    logic [NUM_ENGINES-1:0] eng_req_valid_i;
    mem_request_t           eng_req_i [NUM_ENGINES-1:0];
    logic [NUM_ENGINES-1:0] eng_req_grant_o;
    logic                   mem_req_valid_o;
    mem_request_t           mem_req_o;
    logic                   mem_ready_i;
    logic                   mem_resp_valid_i;
    mem_response_t          mem_resp_i;
    logic [NUM_ENGINES-1:0] eng_ready_i;
    logic [NUM_ENGINES-1:0] eng_resp_valid_o;
    mem_data_t              eng_resp_o;
    logic                   done_o;

    // Scoreboard and stimulus state
    mem_request_t  exp_req_q [$];
    mem_response_t exp_resp_q [$];
    string         test_name = "reset";
    int            value_errors = 0;
    int            other_errors = 0;
    int            checked = 0;
    logic [31:0]   lfsr_state = 32'd66861;
    int            req_left [NUM_ENGINES];
    int            resp_left;
    int            ready_run;
    // Grant as the engines registered it at the last clock edge
    logic [NUM_ENGINES-1:0] grant_seen;

    lane_memory_port lane_memory_port_i (
        .ap_clk              (ap_clk),
        .areset_lane_template(areset_lane_template),
        .eng_req_valid_i     (eng_req_valid_i),
        .eng_req_i           (eng_req_i),
        .eng_req_grant_o     (eng_req_grant_o),
        .mem_req_valid_o     (mem_req_valid_o),
        .mem_req_o           (mem_req_o),
        .mem_ready_i         (mem_ready_i),
        .mem_resp_valid_i    (mem_resp_valid_i),
        .mem_resp_i          (mem_resp_i),
        .eng_ready_i         (eng_ready_i),
        .eng_resp_valid_o    (eng_resp_valid_o),
        .eng_resp_o          (eng_resp_o),
        .done_o              (done_o)
    );

    always #(CLK_PERIOD / 2) ap_clk = ~ap_clk;

    // ------------------------------
    // Random source
    // ------------------------------
    // 32-bit Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic fb;
        fb = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], fb};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v          = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // ------------------------------
    // Reference model
    // ------------------------------
    // First eligible engine after the last grant with wrap-around
    function automatic engine_id_t rr_next(input engine_id_t last,
                                           input logic [NUM_ENGINES-1:0] eligible);
        engine_id_t pick;
        int         idx;
        pick = last;
        for (int off = NUM_ENGINES; off >= 1; off--) begin
            idx = (int'(last) + off) % NUM_ENGINES;
            if (eligible[idx]) begin
                pick = engine_id_t'(idx);
            end
        end
        return pick;
    endfunction

    // The port index replaces whatever id the engine wrote
    function automatic mem_request_t expected_request(input engine_id_t idx,
                                                      input mem_request_t pkt);
        mem_request_t r;
        r           = pkt;
        r.engine_id = idx;
        return r;
    endfunction

    function automatic engine_id_t onehot_index(input logic [NUM_ENGINES-1:0] vec);
        engine_id_t idx;
        idx = '0;
        for (int k = 0; k < NUM_ENGINES; k++) begin
            if (vec[k]) begin
                idx = engine_id_t'(k);
            end
        end
        return idx;
    endfunction

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic check_request(input string name, input mem_request_t expected,
                                 input mem_request_t actual);
        checked++;
        if (actual !== expected) begin
            value_errors++;
            $display("** Error %s: request expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_response(input string name, input mem_response_t expected,
                                  input mem_response_t actual);
        checked++;
        if (actual !== expected) begin
            value_errors++;
            $display("** Error %s: response expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_grant(input string name, input engine_id_t expected,
                               input engine_id_t actual);
        checked++;
        if (actual !== expected) begin
            value_errors++;
            $display("** Error %s: grant expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_done(input string name, input logic expected, input logic actual);
        checked++;
        if (actual !== expected) begin
            value_errors++;
            $display("** Error %s: done flag expected %b, actual %b at %0t",
                     name, expected, actual, $time);
        end
    endtask

    task automatic report_problem(input string what);
        other_errors++;
        $display("Failure in %s at %0t: %s", test_name, $time, what);
    endtask

    // Samples 1 ns after each rising edge and before the stimulus moves
    initial begin : compare_outputs
        logic [NUM_ENGINES-1:0] grant_prev;
        logic [NUM_ENGINES-1:0] valid_prev;
        logic [NUM_ENGINES-1:0] ready_prev;
        logic [NUM_ENGINES-1:0] eligible;
        engine_id_t             last_grant;
        engine_id_t             idx;
        mem_response_t          got;
        grant_prev = '0;
        valid_prev = '0;
        ready_prev = '0;
        last_grant = engine_id_t'(NUM_ENGINES - 1);
        forever begin
            @(posedge ap_clk);
            #1;
            if (areset_lane_template) begin
                check_done(test_name, 1'b0, done_o);
                if ((|eng_req_grant_o) || mem_req_valid_o || (|eng_resp_valid_o)) begin
                    report_problem("grant or valid output high during reset");
                end
            end else begin
                // Anything still inside the lane holds done low
                if (exp_req_q.size() != 0 || exp_resp_q.size() != 0 || (|valid_prev)) begin
                    check_done(test_name, 1'b0, done_o);
                end
                if (mem_req_valid_o) begin
                    if (exp_req_q.size() == 0) begin
                        report_problem("request at the memory port that was never granted");
                    end else begin
                        check_request(test_name, exp_req_q.pop_front(), mem_req_o);
                    end
                end
                if (eng_resp_valid_o != '0) begin
                    idx = onehot_index(eng_resp_valid_o);
                    if (!$onehot(eng_resp_valid_o)) begin
                        report_problem("response valid raised for more than one engine");
                    end else if (!ready_prev[idx]) begin
                        report_problem("response delivered to an engine that was not ready");
                    end
                    got.engine_id = idx;
                    got.data      = eng_resp_o;
                    if (exp_resp_q.size() == 0) begin
                        report_problem("response delivered that memory never sent");
                    end else begin
                        check_response(test_name, exp_resp_q.pop_front(), got);
                    end
                end
                if (eng_req_grant_o != '0) begin
                    idx = onehot_index(eng_req_grant_o);
                    // Last cycle's grant is still in the entry register
                    eligible = eng_req_valid_i & ~grant_prev;
                    if (!$onehot(eng_req_grant_o) || !eligible[idx]) begin
                        report_problem("grant to several engines or to one with no request");
                    end
                    // Buffer fill equals requests granted and not yet at the memory port
                    if (exp_req_q.size() >= FIFO_PROG_THRESH) begin
                        report_problem("grant while the request buffer was almost full");
                    end
                    check_grant(test_name, rr_next(last_grant, eligible), idx);
                    exp_req_q.push_back(expected_request(idx, eng_req_i[idx]));
                    last_grant = idx;
                end
                if (mem_resp_valid_i) begin
                    exp_resp_q.push_back(mem_resp_i);
                end
            end
            grant_prev = eng_req_grant_o;
            valid_prev = eng_req_valid_i;
            ready_prev = eng_ready_i;
        end
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    function automatic mem_request_t new_request();
        mem_request_t r;
        logic [31:0]  bits;
        bits        = rand_bits(1);
        r.engine_id = engine_id_t'(rand_bits(ENGINE_ID_W));
        r.addr      = rand_bits(32);
        r.write     = bits[0];
        r.data      = rand_bits(32);
        return r;
    endfunction

    // Each engine holds its request until the cycle after its grant
    task automatic drive_engines(input logic always_offer);
        logic [31:0]            bits;
        logic [NUM_ENGINES-1:0] grant_now;
        grant_now = eng_req_grant_o;
        for (int i = 0; i < NUM_ENGINES; i++) begin
            if (grant_seen[i]) begin
                req_left[i]--;
                eng_req_valid_i[i] = 1'b0;
            end
            bits = rand_bits(1);
            if (!eng_req_valid_i[i] && req_left[i] > 0 && (always_offer || bits[0])) begin
                eng_req_i[i]       = new_request();
                eng_req_valid_i[i] = 1'b1;
            end
        end
        grant_seen = grant_now;
    endtask

    // Long low stretches let the request buffer reach almost full
    task automatic drive_memory_ready();
        logic [31:0] bits;
        if (ready_run == 0) begin
            bits        = rand_bits(1);
            mem_ready_i = bits[0];
            ready_run   = bits[0] ? int'(rand_bits(4)) + 1 : int'(rand_bits(5)) + 4;
        end else begin
            ready_run--;
        end
    endtask

    task automatic drive_responses(input int cycle);
        logic [31:0] bits;
        mem_resp_valid_i = 1'b0;
        bits = rand_bits(1);
        if (resp_left > 0 && exp_resp_q.size() < RESP_LIMIT && bits[0]) begin
            mem_resp_i.engine_id = engine_id_t'(rand_bits(ENGINE_ID_W));
            mem_resp_i.data      = rand_bits(32);
            mem_resp_valid_i     = 1'b1;
            resp_left--;
        end
        // Engine 2 is held off at first so later responses queue behind it
        for (int i = 0; i < NUM_ENGINES; i++) begin
            bits           = rand_bits(2);
            eng_ready_i[i] = (bits[1:0] != 2'b00) && !(i == 2 && cycle < 40);
        end
    endtask

    function automatic logic requests_pending();
        logic any;
        any = 1'b0;
        for (int i = 0; i < NUM_ENGINES; i++) begin
            any = any | (req_left[i] > 0);
        end
        return any;
    endfunction

    initial begin : drive_stimulus
        int cycle;
        ap_clk               = 1'b0;
        areset_lane_template = 1'b1;
        eng_req_valid_i      = '0;
        foreach (eng_req_i[i]) begin
            eng_req_i[i] = '0;
        end
        mem_ready_i      = 1'b0;
        mem_resp_valid_i = 1'b0;
        mem_resp_i       = '0;
        eng_ready_i      = '0;
        grant_seen       = '0;
        repeat (RESET_CYCLES) @(posedge ap_clk);
        #2;
        areset_lane_template = 1'b0;

        test_name = "idle";
        repeat (2) @(posedge ap_clk);
        #2;
        check_done(test_name, 1'b1, done_o);

        // Every engine offering while memory is always ready
        test_name   = "round_robin";
        mem_ready_i = 1'b1;
        eng_ready_i = '1;
        foreach (req_left[i]) begin
            req_left[i] = REQ_RR;
        end
        while (requests_pending()) begin
            drive_engines(1'b1);
            @(posedge ap_clk);
            #2;
        end

        test_name = "backpressure";
        foreach (req_left[i]) begin
            req_left[i] = REQ_BP;
        end
        resp_left = NUM_RESP;
        ready_run = 0;
        cycle     = 0;
        while (requests_pending() || resp_left > 0) begin
            drive_engines(1'b0);
            drive_memory_ready();
            drive_responses(cycle);
            cycle++;
            @(posedge ap_clk);
            #2;
        end

        test_name        = "drain";
        mem_ready_i      = 1'b1;
        mem_resp_valid_i = 1'b0;
        eng_ready_i      = '1;
        while (exp_req_q.size() != 0 || exp_resp_q.size() != 0 || !done_o) begin
            @(posedge ap_clk);
            #2;
        end
        repeat (3) @(posedge ap_clk);
        #2;
        check_done(test_name, 1'b1, done_o);

        $display("Summary: %0d results checked, %0d value errors, %0d other errors",
                 checked, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: the lane did not finish its transfers within %0d ns", WATCHDOG_NS);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule : lane_memory_port_tb

`default_nettype wire

/* lane_memory_port.sv */
// Lane memory port top level, joining engine requests toward memory and routing responses back
`timescale 1ns/100ps
`default_nettype none

module lane_memory_port (
    input  logic                                    ap_clk,
    input  logic                                    areset_lane_template,
    input  logic [lane_config_pkg::NUM_ENGINES-1:0] eng_req_valid_i,
    input  lane_packet_pkg::mem_request_t           eng_req_i [lane_config_pkg::NUM_ENGINES-1:0],
    output logic [lane_config_pkg::NUM_ENGINES-1:0] eng_req_grant_o,
    output logic                                    mem_req_valid_o,
    output lane_packet_pkg::mem_request_t           mem_req_o,
    input  logic                                    mem_ready_i,
    input  logic                                    mem_resp_valid_i,
    input  lane_packet_pkg::mem_response_t          mem_resp_i,
    input  logic [lane_config_pkg::NUM_ENGINES-1:0] eng_ready_i,
    output logic [lane_config_pkg::NUM_ENGINES-1:0] eng_resp_valid_o,
    output lane_packet_pkg::mem_data_t              eng_resp_o,
    output logic                                    done_o
);

    import lane_config_pkg::*;
    import lane_packet_pkg::*;

    // ------------------------------
    // Entry registers
    // ------------------------------
    logic [NUM_ENGINES-1:0] eng_req_valid_q;
    mem_request_t           eng_req_q [NUM_ENGINES-1:0];
    logic                   mem_ready_q;
    logic                   mem_resp_valid_q;
    mem_response_t          mem_resp_q;
    logic [NUM_ENGINES-1:0] eng_ready_q;

    // Request path
    logic         req_push;
    mem_request_t req_push_data;
    logic         req_pop;
    mem_request_t req_head;
    logic         req_empty;
    logic         req_almost_full;

    // Response path
    logic          resp_pop;
    mem_response_t resp_head;
    logic          resp_empty;

    logic lane_idle;

    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            eng_req_valid_q  <= '0;
            mem_ready_q      <= 1'b0;
            mem_resp_valid_q <= 1'b0;
            eng_ready_q      <= '0;
        end else begin
            eng_req_valid_q  <= eng_req_valid_i;
            mem_ready_q      <= mem_ready_i;
            mem_resp_valid_q <= mem_resp_valid_i;
            eng_ready_q      <= eng_ready_i;
        end
    end

    always_ff @(posedge ap_clk) begin
        eng_req_q  <= eng_req_i;
        mem_resp_q <= mem_resp_i;
    end

    // ------------------------------
    // Request gathering
    // ------------------------------
    lane_request_arbiter lane_request_arbiter_i (
        .ap_clk              (ap_clk),
        .areset_lane_template(areset_lane_template),
        .req_valid_i         (eng_req_valid_q),
        .req_i               (eng_req_q),
        .buffer_almost_full_i(req_almost_full),
        .grant_o             (eng_req_grant_o),
        .push_o              (req_push),
        .push_data_o         (req_push_data)
    );

    lane_sync_fifo #(
        .payload_t(mem_request_t)
    ) request_fifo_i (
        .ap_clk              (ap_clk),
        .areset_lane_template(areset_lane_template),
        .push_i              (req_push),
        .data_i              (req_push_data),
        .pop_i               (req_pop),
        .data_o              (req_head),
        .empty_o             (req_empty),
        .almost_full_o       (req_almost_full)
    );

    // Drain toward memory while the registered ready is high
    assign req_pop = ~req_empty & mem_ready_q;

    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            mem_req_valid_o <= 1'b0;
        end else begin
            mem_req_valid_o <= req_pop;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (req_pop) begin
            mem_req_o <= req_head;
        end
    end

    // ------------------------------
    // Response routing
    // ------------------------------
    // No back-pressure toward memory, so almost full stays open
    lane_sync_fifo #(
        .payload_t(mem_response_t)
    ) response_fifo_i (
        .ap_clk              (ap_clk),
        .areset_lane_template(areset_lane_template),
        .push_i              (mem_resp_valid_q),
        .data_i              (mem_resp_q),
        .pop_i               (resp_pop),
        .data_o              (resp_head),
        .empty_o             (resp_empty),
        .almost_full_o       ()
    );

    lane_response_router lane_response_router_i (
        .ap_clk              (ap_clk),
        .areset_lane_template(areset_lane_template),
        .buffer_empty_i      (resp_empty),
        .head_i              (resp_head),
        .eng_ready_i         (eng_ready_q),
        .pop_o               (resp_pop),
        .resp_valid_o        (eng_resp_valid_o),
        .resp_data_o         (eng_resp_o)
    );

    // ------------------------------
    // Done flag
    // ------------------------------
    // A response strobe still in its entry register counts as in flight
    assign lane_idle = req_empty & resp_empty & ~(|eng_req_valid_q) & ~mem_resp_valid_q;

    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            done_o <= 1'b0;
        end else begin
            done_o <= lane_idle;
        end
    end

endmodule : lane_memory_port

`default_nettype wire

/* lane_response_router.sv */
// Router that drains the response buffer and hands each response to the engine it names
`timescale 1ns/100ps
`default_nettype none

module lane_response_router (
    input  logic                                    ap_clk,
    input  logic                                    areset_lane_template,
    input  logic                                    buffer_empty_i,
    input  lane_packet_pkg::mem_response_t          head_i,
    input  logic [lane_config_pkg::NUM_ENGINES-1:0] eng_ready_i,
    output logic                                    pop_o,
    output logic [lane_config_pkg::NUM_ENGINES-1:0] resp_valid_o,
    output lane_packet_pkg::mem_data_t              resp_data_o
);

    import lane_config_pkg::*;
    import lane_packet_pkg::*;

    logic [NUM_ENGINES-1:0] head_onehot;
    logic                   head_ready;

    // ------------------------------
    // Head decode
    // ------------------------------
    always_comb begin
        head_onehot                   = '0;
        head_onehot[head_i.engine_id] = 1'b1;
    end

    // Only the target engine's ready counts
    assign head_ready = |(head_onehot & eng_ready_i);

    // A blocked head holds back every response behind it
    assign pop_o = ~buffer_empty_i & head_ready;

    // ------------------------------
    // Output register
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            resp_valid_o <= '0;
        end else if (pop_o) begin
            resp_valid_o <= head_onehot;
        end else begin
            resp_valid_o <= '0;
        end
    end

    // Data word shared by all engines
    always_ff @(posedge ap_clk) begin
        if (pop_o) begin
            resp_data_o <= head_i.data;
        end
    end

endmodule : lane_response_router

`default_nettype wire

/* lane_request_arbiter.sv */
// Round-robin arbiter that moves one engine request per cycle into the request buffer
`timescale 1ns/100ps
`default_nettype none

module lane_request_arbiter (
    input  logic                                    ap_clk,
    input  logic                                    areset_lane_template,
    input  logic [lane_config_pkg::NUM_ENGINES-1:0] req_valid_i,
    input  lane_packet_pkg::mem_request_t           req_i [lane_config_pkg::NUM_ENGINES-1:0],
    input  logic                                    buffer_almost_full_i,
    output logic [lane_config_pkg::NUM_ENGINES-1:0] grant_o,
    output logic                                    push_o,
    output lane_packet_pkg::mem_request_t           push_data_o
);

    import lane_config_pkg::*;
    import lane_packet_pkg::*;

    engine_id_t             last_q;
    logic [NUM_ENGINES-1:0] granted_q;
    logic [NUM_ENGINES-1:0] eligible;
    engine_id_t             grant_idx;
    logic                   grant_found;

    // ------------------------------
    // Request masking
    // ------------------------------
    // The entry register still holds the granted request for one cycle
    // after the grant, so that engine sits out one cycle
    assign eligible = req_valid_i & ~granted_q;

    // ------------------------------
    // Round-robin pick
    // ------------------------------
    // First eligible engine after the last one granted, wrapping around
    always_comb begin : pick_next
        int unsigned idx;
        grant_found = 1'b0;
        grant_idx   = last_q;
        for (int off = 1; off <= NUM_ENGINES; off++) begin
            idx = (int'(last_q) + off) % NUM_ENGINES;
            if (!grant_found && eligible[idx]) begin
                grant_found = 1'b1;
                grant_idx   = engine_id_t'(idx);
            end
        end
    end

    assign push_o = grant_found & ~buffer_almost_full_i;

    always_comb begin
        grant_o = '0;
        if (push_o) begin
            grant_o[grant_idx] = 1'b1;
        end
    end

    // Engine id comes from the port, not from the engine's packet
    always_comb begin
        push_data_o           = req_i[grant_idx];
        push_data_o.engine_id = grant_idx;
    end

    // ------------------------------
    // Arbiter state
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            last_q    <= engine_id_t'(NUM_ENGINES - 1);
            granted_q <= '0;
        end else begin
            granted_q <= grant_o;
            if (push_o) begin
                last_q <= grant_idx;
            end
        end
    end

endmodule : lane_request_arbiter

`default_nettype wire

/* lane_sync_fifo.sv */
// Show-ahead synchronous FIFO, instantiated once for request packets and once for responses
`timescale 1ns/100ps
`default_nettype none

module lane_sync_fifo #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     ap_clk,
    input  logic     areset_lane_template,
    input  logic     push_i,
    input  payload_t data_i,
    input  logic     pop_i,
    output payload_t data_o,
    output logic     empty_o,
    output logic     almost_full_o
);

    import lane_config_pkg::*;

    // ------------------------------
    // Storage and pointers
    // ------------------------------
    payload_t mem [FIFO_DEPTH-1:0];

    logic [FIFO_PTR_W-1:0]   wr_ptr;
    logic [FIFO_PTR_W-1:0]   rd_ptr;
    logic [FIFO_COUNT_W-1:0] count;

    logic full;
    logic push_ok;
    logic pop_ok;

    assign full    = (count == FIFO_COUNT_W'(FIFO_DEPTH));
    assign push_ok = push_i & ~full;
    // Popping an empty buffer is ignored
    assign pop_ok  = pop_i & ~empty_o;

    // ------------------------------
    // Write side
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            wr_ptr <= '0;
        end else if (push_ok) begin
            if (wr_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    // ------------------------------
    // Read side
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            rd_ptr <= '0;
        end else if (pop_ok) begin
            if (rd_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) begin
                rd_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Fill count, both strobes in one cycle leave it unchanged
    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            count <= '0;
        end else begin
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head word is visible without a read delay
    assign data_o        = mem[rd_ptr];
    assign empty_o       = (count == '0);
    assign almost_full_o = (count >= FIFO_COUNT_W'(FIFO_PROG_THRESH));

endmodule : lane_sync_fifo

`default_nettype wire

/* lane_packet_pkg.sv */
// Memory packet formats exchanged between engines, the lane buffers and the memory port
`default_nettype none

package lane_packet_pkg;

    import lane_config_pkg::*;

    // ------------------------------
    // Field types
    // ------------------------------
    typedef logic [ENGINE_ID_W-1:0] engine_id_t;
    typedef logic [31:0]            mem_addr_t;
    typedef logic [31:0]            mem_data_t;

    // ------------------------------
    // Packets
    // ------------------------------
    // Request toward memory, 67 bits
    typedef struct packed {
        engine_id_t engine_id;
        mem_addr_t  addr;
        logic       write;
        mem_data_t  data;
    } mem_request_t;

    // Response from memory, 34 bits
    // engine_id selects the engine that gets the data
    typedef struct packed {
        engine_id_t engine_id;
        mem_data_t  data;
    } mem_response_t;

endpackage : lane_packet_pkg

`default_nettype wire

/* lane_config_pkg.sv */
// Lane configuration constants, imported by the buffers, the arbiter, the router and the top level
`default_nettype none

package lane_config_pkg;

    // ------------------------------
    // Engine ports
    // ------------------------------
    localparam int NUM_ENGINES = 4;
    localparam int ENGINE_ID_W = 2;

    // ------------------------------
    // Request and response buffers
    // ------------------------------
    localparam int FIFO_DEPTH       = 16;
    localparam int FIFO_PROG_THRESH = 12;

    // Pointer and fill count widths
    localparam int FIFO_PTR_W   = $clog2(FIFO_DEPTH);
    localparam int FIFO_COUNT_W = $clog2(FIFO_DEPTH + 1);

endpackage : lane_config_pkg

`default_nettype wire
